//--- verification/mul_red_trace.txt
# columns: valid mode operand twiddle expected, all hex
# mode 0 kyber (hi:lo mod 3329 each), mode 1 dilithium; expected unused when valid is 0
# kyber lanes, limbs 0, 3328, 3329, 4095, lanes differ
1 0 000000 000000 000000
1 0 D00001 001D00 D00D00
1 0 FFFFFF FFFFFF 354354
1 0 D00FFF D00002 0015FC
1 0 002000 003FFF 006000
1 0 D01064 123064 00000D
1 0 3E8001 3E8001 514001
1 0 ABC001 001DEF ABC0EE
1 0 800010 800010 C15100
1 0 7FE002 001001 7FE002
0 0 000000 000000 000000
# dilithium, (hi * 4096 + lo) mod 8380417
1 1 000000 000000 000000
1 1 FFFFFF FFFFFF 008FFB
1 1 7FE001 001001 000000
1 1 FFC002 001001 000000
1 1 7FE000 001001 7FE000
1 1 7FE002 001001 000001
1 1 002005 003001 006005
1 1 FFF000 FFF000 006FFC
1 1 000FFF 000FFF 001FFF
1 1 800010 800010 0038FE
1 1 D00FFF D00002 24AAD9
0 1 FFFFFF FFFFFF 000000
# alternating modes, same words
1 0 FFFFFF FFFFFF 354354
1 1 FFFFFF FFFFFF 008FFB
1 0 800010 800010 C15100
1 1 800010 800010 0038FE
1 0 D00FFF D00002 0015FC
1 1 D00FFF D00002 24AAD9
1 0 7FE002 001001 7FE002
1 1 7FE002 001001 000001

//--- build.f
logic/mulred_pkg.sv
logic/limb_multiplier.sv
logic/kyber_reduce.sv
logic/dilithium_reduce.sv
logic/result_stage.sv
logic/mul_red_top.sv
verification/tb_mul_red.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mul_red
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/tb_mul_red.sv
`timescale 1ns/1ps

module tb_mul_red;
    import mulred_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DLY = 1;
    localparam int SEED = 96;
    localparam int MAX_BUBBLE = 3;
    localparam string TRACE_FILE = "verification/mul_red_trace.txt";

    logic clk;
    logic rst;
    logic in_valid;
    red_mode_t mode;
    logic [WORD_W-1:0] operand;
    logic [WORD_W-1:0] twiddle;
    logic out_valid;
    logic [WORD_W-1:0] result;

    // trace contents with one entry per data line
    logic vec_valid [$];
    logic vec_mode [$];
    logic [WORD_W-1:0] vec_op [$];
    logic [WORD_W-1:0] vec_tw [$];
    logic [WORD_W-1:0] vec_exp [$];
    int vec_line [$];
    // idle cycles before each vector in the second pass
    int bubbles [$];

    // pending results with the oldest first
    logic [WORD_W-1:0] exp_q [$];
    string name_q [$];

    // in_valid at the last PIPE_LAT falling edges
    logic [PIPE_LAT-1:0] vld_hist;

    int limit_cycles;

    mul_red_top #(
        .PE_SHIFT (0)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .mode      (mode),
        .operand   (operand),
        .twiddle   (twiddle),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // checking
    // ------------------------------------------------------------

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [WORD_W-1:0] expected,
                               input logic [WORD_W-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %s expected %06h actual %06h", name, expected, actual));
        end
    endtask

    // ------------------------------------------------------------
    // trace and stimulus
    // ------------------------------------------------------------

    task automatic load_trace();
        int fd;
        int n;
        int line_no;
        string line;
        logic v;
        logic m;
        logic [WORD_W-1:0] op;
        logic [WORD_W-1:0] tw;
        logic [WORD_W-1:0] ex;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            abort_run({"cannot open trace file ", TRACE_FILE});
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            // comment lines
            if (line.len() == 0 || line.substr(0, 0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h", v, m, op, tw, ex);
            // blank line
            if (n <= 0) continue;
            if (n != 5) begin
                abort_run($sformatf("trace line %0d does not hold five fields", line_no));
            end
            vec_valid.push_back(v);
            vec_mode.push_back(m);
            vec_op.push_back(op);
            vec_tw.push_back(tw);
            vec_exp.push_back(ex);
            vec_line.push_back(line_no);
        end
        $fclose(fd);
        if (vec_valid.size() == 0) begin
            abort_run("trace file holds no vectors");
        end
    endtask

    task automatic plan_bubbles(output int total);
        total = 0;
        foreach (vec_valid[i]) begin
            bubbles.push_back(int'($urandom % (MAX_BUBBLE + 1)));
            total += bubbles[i];
        end
    endtask

    // one trace line that is queued for checking if valid
    task automatic drive_vector(input int idx, input int pass);
        @(posedge clk);
        #DRIVE_DLY;
        in_valid = vec_valid[idx];
        mode = red_mode_t'(vec_mode[idx]);
        operand = vec_op[idx];
        twiddle = vec_tw[idx];
        if (vec_valid[idx]) begin
            exp_q.push_back(vec_exp[idx]);
            name_q.push_back($sformatf("trace line %0d pass %0d", vec_line[idx], pass));
        end
    endtask

    // junk data flows through the pipe but must never surface
    task automatic drive_idle();
        @(posedge clk);
        #DRIVE_DLY;
        in_valid = 1'b0;
        mode = ($urandom % 2 == 0) ? MODE_KYBER : MODE_DILITHIUM;
        operand = WORD_W'($urandom);
        twiddle = WORD_W'($urandom);
    endtask

    // ------------------------------------------------------------
    // monitor sampled at the falling edge
    // ------------------------------------------------------------

    // in_valid seen here is captured at the next rising edge
    // and returns as out_valid PIPE_LAT falling edges later
    initial begin
        vld_hist = '0;
        forever begin
            @(negedge clk);
            check_value("out_valid timing", WORD_W'(vld_hist[PIPE_LAT-1]), WORD_W'(out_valid));
            if (out_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    abort_run("out_valid went high with no result pending");
                end else begin
                    check_value(name_q.pop_front(), exp_q.pop_front(), result);
                end
            end
            vld_hist = {vld_hist[PIPE_LAT-2:0], in_valid};
        end
    end

    // limit from trace length and the chosen bubbles
    initial begin
        wait (limit_cycles > 0);
        #(limit_cycles * CLK_PERIOD);
        abort_run($sformatf("watchdog expired after %0d cycles", limit_cycles));
    end

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        int bubble_total;
        rst = 1'b1;
        in_valid = 1'b0;
        mode = MODE_KYBER;
        operand = '0;
        twiddle = '0;
        void'($urandom(SEED));
        load_trace();
        plan_bubbles(bubble_total);
        limit_cycles = RESET_CYCLES + 2 * vec_valid.size() + bubble_total + PIPE_LAT + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        // first pass with every line back to back
        foreach (vec_valid[i]) begin
            drive_vector(i, 0);
        end
        // second pass with random gaps
        foreach (vec_valid[i]) begin
            repeat (bubbles[i]) drive_idle();
            drive_vector(i, 1);
        end
        // drain the fixed latency
        repeat (PIPE_LAT + 2) drive_idle();

        if (exp_q.size() != 0) begin
            abort_run($sformatf("%0d expected results never came out", exp_q.size()));
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- logic/mul_red_top.sv
`timescale 1ns/1ps

module mul_red_top #(
    parameter int PE_SHIFT = 0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  mulred_pkg::red_mode_t         mode,
    input  logic [mulred_pkg::WORD_W-1:0] operand,
    input  logic [mulred_pkg::WORD_W-1:0] twiddle,
    output logic                          out_valid,
    output logic [mulred_pkg::WORD_W-1:0] result
);
    import mulred_pkg::*;

    // registered lane products
    logic [WORD_W-1:0] prod_hi;
    logic [WORD_W-1:0] prod_lo;

    // reducer outputs, two cycles after the products
    logic [LIMB_W-1:0] kyber_hi;
    logic [LIMB_W-1:0] kyber_lo;
    logic [DIL_W-1:0] dil_residue;

    // ------------------------------------------------------------
    // cycle 1: limb products
    // ------------------------------------------------------------

    limb_multiplier i_limb_multiplier (
        .clk     (clk),
        .rst     (rst),
        .operand (operand),
        .twiddle (twiddle),
        .prod_hi (prod_hi),
        .prod_lo (prod_lo)
    );

    // ------------------------------------------------------------
    // cycles 2-3: reductions, all run every cycle
    // ------------------------------------------------------------

    // one barrett reducer per lane
    kyber_reduce i_kyber_hi (
        .clk     (clk),
        .rst     (rst),
        .product (prod_hi),
        .residue (kyber_hi)
    );

    kyber_reduce i_kyber_lo (
        .clk     (clk),
        .rst     (rst),
        .product (prod_lo),
        .residue (kyber_lo)
    );

    // limb weight fixed per processing element
    dilithium_reduce #(
        .PE_SHIFT (PE_SHIFT)
    ) i_dilithium_reduce (
        .clk     (clk),
        .rst     (rst),
        .prod_hi (prod_hi),
        .prod_lo (prod_lo),
        .residue (dil_residue)
    );

    // ------------------------------------------------------------
    // cycle 4: mode select
    // ------------------------------------------------------------

    result_stage i_result_stage (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .mode        (mode),
        .kyber_hi    (kyber_hi),
        .kyber_lo    (kyber_lo),
        .dil_residue (dil_residue),
        .out_valid   (out_valid),
        .result      (result)
    );

endmodule

//--- logic/result_stage.sv
`timescale 1ns/1ps

module result_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  mulred_pkg::red_mode_t         mode,
    input  logic [mulred_pkg::LIMB_W-1:0] kyber_hi,
    input  logic [mulred_pkg::LIMB_W-1:0] kyber_lo,
    input  logic [mulred_pkg::DIL_W-1:0]  dil_residue,
    output logic                          out_valid,
    output logic [mulred_pkg::WORD_W-1:0] result
);
    import mulred_pkg::*;

    // multiply + two reduce stages
    localparam int DLY = PIPE_LAT - 1;

    logic [DLY-1:0] vld_d;
    red_mode_t mode_d [DLY];

    logic [WORD_W-1:0] sel_result;

    // ------------------------------------------------------------
    // valid and mode delay line
    // ------------------------------------------------------------

    // runs in step with the residues
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_d <= '0;
            for (int i = 0; i < DLY; i++) begin
                mode_d[i] <= MODE_KYBER;
            end
        end else begin
            vld_d <= {vld_d[DLY-2:0], in_valid};
            mode_d[0] <= mode;
            for (int i = 1; i < DLY; i++) begin
                mode_d[i] <= mode_d[i-1];
            end
        end
    end

    // ------------------------------------------------------------
    // output register
    // ------------------------------------------------------------

    // dilithium residue zero-extended, kyber lanes packed hi:lo
    assign sel_result = (mode_d[DLY-1] == MODE_DILITHIUM)
                      ? {{(WORD_W-DIL_W){1'b0}}, dil_residue}
                      : {kyber_hi, kyber_lo};

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= vld_d[DLY-1];
            result    <= sel_result;
        end
    end

endmodule

//--- logic/dilithium_reduce.sv
`timescale 1ns/1ps

module dilithium_reduce #(
    parameter int PE_SHIFT = 0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [mulred_pkg::WORD_W-1:0] prod_hi,
    input  logic [mulred_pkg::WORD_W-1:0] prod_lo,
    output logic [mulred_pkg::DIL_W-1:0]  residue
);
    import mulred_pkg::*;

    // 2^23 = 2^13 - 1 mod q
    localparam int FOLD_K = 13;
    // widths after each fold pass
    localparam int F1_W = 39;
    localparam int F2_W = 30;
    localparam int F3_W = DIL_W + 1;

    localparam logic [F3_W-1:0] Q_D = F3_W'(DIL_Q);
    localparam logic [F3_W-1:0] FOLD_C = F3_W'((1 << FOLD_K) - 1);

    logic [WIDE_W-1:0] wide_sum;

    // first pass, 48 -> 39 bits
    logic [WIDE_W-DIL_W-1:0] f1_hi;
    logic [F1_W-1:0] fold1;
    // second pass, 39 -> 30 bits
    logic [F1_W-DIL_W-1:0] f2_hi;
    logic [F2_W-1:0] fold2;

    logic [F2_W-1:0] fold_q;

    // third pass, 30 -> 24 bits
    logic [F2_W-DIL_W-1:0] f3_hi;
    logic [F3_W-1:0] fold3;
    // last pass leaves at most one carry bit to fold
    logic [F3_W-1:0] fold4;

    // ------------------------------------------------------------
    // weighted recombination
    // ------------------------------------------------------------

    // hi limb weighted 2^(12+PE_SHIFT), lo limb 2^PE_SHIFT
    assign wide_sum = (WIDE_W'(prod_hi) << (LIMB_W + PE_SHIFT))
                    + (WIDE_W'(prod_lo) << PE_SHIFT);

    // ------------------------------------------------------------
    // stage one: two folds
    // ------------------------------------------------------------

    assign f1_hi = wide_sum[WIDE_W-1:DIL_W];
    // hi * 2^13 always covers hi, no underflow
    assign fold1 = F1_W'(wide_sum[DIL_W-1:0])
                 + (F1_W'(f1_hi) << FOLD_K)
                 - F1_W'(f1_hi);

    assign f2_hi = fold1[F1_W-1:DIL_W];
    assign fold2 = F2_W'(fold1[DIL_W-1:0])
                 + (F2_W'(f2_hi) << FOLD_K)
                 - F2_W'(f2_hi);

    always_ff @(posedge clk) begin
        if (rst) begin
            fold_q <= '0;
        end else begin
            fold_q <= fold2;
        end
    end

    // ------------------------------------------------------------
    // stage two: fold down to 24 bits and correct
    // ------------------------------------------------------------

    assign f3_hi = fold_q[F2_W-1:DIL_W];
    assign fold3 = F3_W'(fold_q[DIL_W-1:0])
                 + (F3_W'(f3_hi) << FOLD_K)
                 - F3_W'(f3_hi);

    // bit 23 worth 2^13 - 1, result below 2q
    assign fold4 = F3_W'(fold3[DIL_W-1:0]) + (fold3[DIL_W] ? FOLD_C : '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            residue <= '0;
        end else if (fold4 >= Q_D) begin
            residue <= DIL_W'(fold4 - Q_D);
        end else begin
            residue <= fold4[DIL_W-1:0];
        end
    end

endmodule

//--- logic/kyber_reduce.sv
`timescale 1ns/1ps

module kyber_reduce (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [mulred_pkg::WORD_W-1:0] product,
    output logic [mulred_pkg::LIMB_W-1:0] residue
);
    import mulred_pkg::*;

    // barrett shift covers the whole product width
    localparam int BARRETT_K = WORD_W;
    // floor(2^24 / 3329) = 5039
    localparam int BARRETT_M = (1 << BARRETT_K) / KYBER_Q;
    // quotient width, estimate never exceeds the constant
    localparam int QT_W = $clog2(BARRETT_M + 1);
    // remainder before correction is below 2q
    localparam int R_W = LIMB_W + 1;

    localparam logic [QT_W-1:0] M_C = QT_W'(BARRETT_M);
    localparam logic [R_W-1:0] Q_R = R_W'(KYBER_Q);

    logic [WORD_W+QT_W-1:0] est_full;
    logic [QT_W-1:0] q_est;

    // stage one registers
    logic [WORD_W-1:0] prod_q;
    logic [QT_W-1:0] q_est_q;

    logic [WORD_W-1:0] diff;
    logic [R_W-1:0] rem;

    // ------------------------------------------------------------
    // stage one: quotient estimate
    // ------------------------------------------------------------

    // x * m / 2^k, undershoots floor(x/q) by at most one
    assign est_full = (WORD_W+QT_W)'(product) * (WORD_W+QT_W)'(M_C);
    assign q_est = est_full[WORD_W+QT_W-1:BARRETT_K];

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_q  <= '0;
            q_est_q <= '0;
        end else begin
            prod_q  <= product;
            q_est_q <= q_est;
        end
    end

    // ------------------------------------------------------------
    // stage two: subtract and correct
    // ------------------------------------------------------------

    assign diff = prod_q - (WORD_W'(q_est_q) * WORD_W'(KYBER_Q));
    // upper bits are zero here
    assign rem = diff[R_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            residue <= '0;
        end else if (rem >= Q_R) begin
            residue <= LIMB_W'(rem - Q_R);
        end else begin
            residue <= rem[LIMB_W-1:0];
        end
    end

endmodule

//--- logic/limb_multiplier.sv
`timescale 1ns/1ps

module limb_multiplier (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [mulred_pkg::WORD_W-1:0] operand,
    input  logic [mulred_pkg::WORD_W-1:0] twiddle,
    output logic [mulred_pkg::WORD_W-1:0] prod_hi,
    output logic [mulred_pkg::WORD_W-1:0] prod_lo
);
    import mulred_pkg::*;

    // ------------------------------------------------------------
    // limb split
    // ------------------------------------------------------------

    logic [LIMB_W-1:0] op_hi;
    logic [LIMB_W-1:0] op_lo;
    logic [LIMB_W-1:0] tw_hi;
    logic [LIMB_W-1:0] tw_lo;

    // full-width products before the register
    logic [WORD_W-1:0] mult_hi;
    logic [WORD_W-1:0] mult_lo;

    // upper limb of each word
    assign op_hi = operand[WORD_W-1:LIMB_W];
    assign tw_hi = twiddle[WORD_W-1:LIMB_W];

    // lower limb of each word
    assign op_lo = operand[LIMB_W-1:0];
    assign tw_lo = twiddle[LIMB_W-1:0];

    // ------------------------------------------------------------
    // lane products
    // ------------------------------------------------------------

    // 12x12 never overflows 24 bits
    assign mult_hi = WORD_W'(op_hi) * WORD_W'(tw_hi);
    assign mult_lo = WORD_W'(op_lo) * WORD_W'(tw_lo);

    // one register stage, first pipeline cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            prod_hi <= '0;
            prod_lo <= '0;
        end else begin
            prod_hi <= mult_hi;
            prod_lo <= mult_lo;
        end
    end

endmodule

//--- logic/mulred_pkg.sv
package mulred_pkg;

    // ------------------------------------------------------------
    // datapath widths
    // ------------------------------------------------------------

    // one limb of an operand or twiddle word
    localparam int LIMB_W = 12;

    // operand, twiddle and packed result
    localparam int WORD_W = 24;

    // weighted dilithium sum, wide enough for PE_SHIFT of 12
    localparam int WIDE_W = 48;

    // ------------------------------------------------------------
    // moduli
    // ------------------------------------------------------------

    // kyber prime, residue fits one limb
    localparam int KYBER_Q = 3329;

    // dilithium prime, 2^23 - 2^13 + 1
    localparam int DIL_Q = 8380417;

    // dilithium residue width
    localparam int DIL_W = 23;

    // ------------------------------------------------------------
    // pipeline
    // ------------------------------------------------------------

    // multiply + two reduce stages + result register
    localparam int PIPE_LAT = 4;

    // selects the per-lane kyber reduction or the recombined dilithium one
    typedef enum logic {
        MODE_KYBER     = 1'b0,
        MODE_DILITHIUM = 1'b1
    } red_mode_t;

endpackage
